// ==== debug_loader.sv ====
`timescale 1ns/10ps

module debug_loader
#(
    parameter int NBITS     = 32,
    parameter int MEM_WORDS = 64
)
(
    input  logic                          i_WriteDebug,
    input  logic                          i_rst_n,
    input  logic                          i_rx_valid,
    input  logic [7:0]                    i_rx_byte,
    input  logic                          i_prog_clear,
    output logic                          o_wr_en,
    output logic [$clog2(MEM_WORDS)-1:0]  o_wr_addr,
    output logic [NBITS-1:0]              o_wr_data
);

    // word index width into the instruction memory
    localparam int AW     = $clog2(MEM_WORDS);
    // width of one incoming debug byte
    localparam int BYTE_W = 8;
    // byte counter width, enough for one word worth of bytes
    localparam int CNT_W  = $clog2(fetch_pkg::BYTES_PER_WORD);
    // count value of the byte that completes a word
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(fetch_pkg::BYTES_PER_WORD - 1);

    // bytes already taken into the current word
    logic [CNT_W-1:0] byte_cnt;
    // word assembly register, shifts left by one byte per strobe
    logic [NBITS-1:0] shift_q;
    // index of the next memory word to write
    logic [AW-1:0]    wr_idx;
    // high on the strobe that carries the last byte of a word
    logic             word_done;

    assign word_done = i_rx_valid && (byte_cnt == LAST_BYTE);

    // byte counter
    // a clear drops a partly assembled word by restarting the count
    always_ff @(posedge i_WriteDebug or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            byte_cnt <= '0;
        end
        else if (i_prog_clear)
        begin
            byte_cnt <= '0;
        end
        else if (word_done)
        begin
            byte_cnt <= '0;
        end
        else if (i_rx_valid)
        begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // msb first, so earlier bytes end up in the upper lanes
    // old contents fall out the top after a full word
    always_ff @(posedge i_WriteDebug)
    begin
        if (i_rx_valid)
        begin
            shift_q <= {shift_q[NBITS-BYTE_W-1:0], i_rx_byte};
        end
    end

    // write pulse, one cycle after the last byte of a word
    always_ff @(posedge i_WriteDebug or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wr_en <= 1'b0;
        end
        else
        begin
            o_wr_en <= word_done && !i_prog_clear;
        end
    end

    // word index steps once the write pulse has gone out
    always_ff @(posedge i_WriteDebug or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_idx <= '0;
        end
        else if (i_prog_clear)
        begin
            wr_idx <= '0;
        end
        else if (o_wr_en)
        begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    // the shift register holds the full word during the pulse cycle
    assign o_wr_addr = wr_idx;
    assign o_wr_data = shift_q;

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // shared constants of the instruction fetch subsystem
    // the top level takes its parameter defaults from here and passes them down

    // instruction word width in bits
    // one word is one MIPS-style instruction
    localparam int NBITS_DEFAULT = 32;

    // instruction memory depth in words
    // the word index from the loader and the read index from the fetch
    // stage both wrap inside this range
    localparam int MEM_WORDS_DEFAULT = 64;

    // bytes that the debug side packs into one word
    // most significant byte arrives first
    localparam int BYTES_PER_WORD = 4;

    // byte distance between two consecutive instructions
    // the pc counts bytes, the memory counts words
    localparam int PC_STEP = 4;

    // all-ones word that marks the end of a program
    // fetching stops when this word comes back from memory
    localparam logic [NBITS_DEFAULT-1:0] HALT_WORD = 32'hFFFF_FFFF;

endpackage

// ==== fetch_properties.sv ====
`timescale 1ns/10ps

module fetch_properties
#(
    parameter int NBITS = 32
)
(
    input logic             i_WriteDebug,
    input logic             i_rst_n,
    input logic             i_prog_clear,
    input logic             i_step,
    input logic [NBITS-1:0] i_instr,
    input logic             i_instr_valid,
    input logic             i_halted
);

    localparam logic [NBITS-1:0] HALT = NBITS'(fetch_pkg::HALT_WORD);

    // number of assertion failures so far
    int fail_count = 0;

    // nothing leaves the fetch stage once it has stopped
    valid_not_halted: assert property (@(posedge i_WriteDebug) disable iff (!i_rst_n)
        i_instr_valid |-> !i_halted)
    else
    begin
        fail_count++;
        $error("instruction valid while halted");
    end

    // the halt word itself is never delivered
    no_halt_word_out: assert property (@(posedge i_WriteDebug) disable iff (!i_rst_n)
        i_instr_valid |-> (i_instr != HALT))
    else
    begin
        fail_count++;
        $error("halt word delivered as an instruction");
    end

    // one cycle from step to instruction
    valid_after_step: assert property (@(posedge i_WriteDebug) disable iff (!i_rst_n)
        i_instr_valid |-> $past(i_step))
    else
    begin
        fail_count++;
        $error("instruction valid without a step one cycle before");
    end

    // halted level only drops on a reload
    halted_sticky: assert property (@(posedge i_WriteDebug) disable iff (!i_rst_n)
        (i_halted && !i_prog_clear) |=> i_halted)
    else
    begin
        fail_count++;
        $error("halted dropped without a program clear");
    end

endmodule

bind fetch_top fetch_properties #(.NBITS(NBITS)) u_props (
    .i_WriteDebug  (i_WriteDebug),
    .i_rst_n       (i_rst_n),
    .i_prog_clear  (i_prog_clear),
    .i_step        (i_step),
    .i_instr       (o_instr),
    .i_instr_valid (o_instr_valid),
    .i_halted      (o_halted)
);

// ==== fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage
#(
    parameter int NBITS     = 32,
    parameter int MEM_WORDS = 64
)
(
    input  logic                          i_WriteDebug,
    input  logic                          i_rst_n,
    input  logic                          i_step,
    input  logic                          i_prog_clear,
    input  logic [NBITS-1:0]              i_rd_data,
    output logic                          o_rd_en,
    output logic [$clog2(MEM_WORDS)-1:0]  o_rd_addr,
    output logic [NBITS-1:0]              o_instr,
    output logic [NBITS-1:0]              o_instr_pc,
    output logic                          o_instr_valid,
    output logic                          o_halted
);

    // word index width into the instruction memory
    localparam int AW      = $clog2(MEM_WORDS);
    // pc bits below the word index
    localparam int STEP_SH = $clog2(fetch_pkg::PC_STEP);
    // halt word resized to the local word width
    localparam logic [NBITS-1:0] HALT = NBITS'(fetch_pkg::HALT_WORD);

    // byte address of the next instruction to fetch
    logic [NBITS-1:0] pc;
    // read in flight, data shows up on i_rd_data this cycle
    logic             rd_pending;
    // byte address of the read in flight
    logic [NBITS-1:0] rd_pc;
    // returning word is the halt word
    logic             halt_hit;
    // step accepted in this cycle
    logic             step_ok;

    // returning word is the end-of-program marker
    assign halt_hit = rd_pending && (i_rd_data == HALT);

    // step taken only while running and not on the halt word itself
    // a clear in the same cycle wins over the step
    assign step_ok = i_step && !o_halted && !halt_hit && !i_prog_clear;

    // memory read request, pc in bytes turned into a word index
    assign o_rd_en   = step_ok;
    assign o_rd_addr = pc[STEP_SH +: AW];

    // program counter
    // rewinds to the halt word so a later run sees where it stopped
    always_ff @(posedge i_WriteDebug or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            pc <= '0;
        end
        else if (i_prog_clear)
        begin
            pc <= '0;
        end
        else if (halt_hit)
        begin
            pc <= rd_pc;
        end
        else if (step_ok)
        begin
            pc <= pc + NBITS'(fetch_pkg::PC_STEP);
        end
    end

    // in-flight tracking
    // back to back steps keep it set, one read returning per cycle
    // the halt word cancels it, no new read goes out in that cycle
    always_ff @(posedge i_WriteDebug or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rd_pending <= 1'b0;
        end
        else if (i_prog_clear)
        begin
            rd_pending <= 1'b0;
        end
        else
        begin
            rd_pending <= step_ok;
        end
    end

    // address travels alongside the read
    always_ff @(posedge i_WriteDebug)
    begin
        if (step_ok)
        begin
            rd_pc <= pc;
        end
    end

    // halted level, held until the debug side reloads
    always_ff @(posedge i_WriteDebug or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_halted <= 1'b0;
        end
        else if (i_prog_clear)
        begin
            o_halted <= 1'b0;
        end
        else if (halt_hit)
        begin
            o_halted <= 1'b1;
        end
    end

    // memory output register is the instruction register
    // valid pulses one cycle after the accepted step, never for the halt word
    assign o_instr       = i_rd_data;
    assign o_instr_pc    = rd_pc;
    assign o_instr_valid = rd_pending && !halt_hit;

endmodule

// ==== fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;

    localparam int NBITS     = fetch_pkg::NBITS_DEFAULT;
    localparam int MEM_WORDS = fetch_pkg::MEM_WORDS_DEFAULT;
    localparam int N_ROWS    = 10;
    // run limit grows with the program table
    localparam int WATCHDOG_CYCLES = N_ROWS * 40 + 200;

    logic             i_WriteDebug;
    logic             i_rst_n;
    logic             i_rx_valid;
    logic [7:0]       i_rx_byte;
    logic             i_prog_clear;
    logic             i_step;
    logic [NBITS-1:0] o_instr;
    logic [NBITS-1:0] o_instr_pc;
    logic             o_instr_valid;
    logic             o_halted;

    // program table, one row per word
    // program 1 ends on the halt word, program 2 overwrites its first words
    string            row_name [N_ROWS] = '{"first_word", "byte_order", "lw_word",
        "add_word", "sw_word", "zero_word", "halt_word", "reload_0", "reload_1", "reload_2"};
    int               row_prog [N_ROWS] = '{1, 1, 1, 1, 1, 1, 1, 2, 2, 2};
    logic [NBITS-1:0] row_word [N_ROWS] = '{32'h2408_0005, 32'h1122_3344, 32'h8C09_0004,
        32'h0109_5020, 32'hAC0A_0008, 32'h0000_0000, fetch_pkg::HALT_WORD,
        32'hDEAD_BEEF, 32'h0123_4567, 32'hA5A5_5A5A};

    // expected memory image, built from the rows as they are loaded
    logic [NBITS-1:0] img_word [MEM_WORDS];
    string            img_name [MEM_WORDS];

    // every valid pulse seen by the monitor
    logic [NBITS-1:0] got_instr [$];
    logic [NBITS-1:0] got_pc [$];
    logic             step_seen;

    fetch_top #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) i_dut (
        .i_WriteDebug  (i_WriteDebug),
        .i_rst_n       (i_rst_n),
        .i_rx_valid    (i_rx_valid),
        .i_rx_byte     (i_rx_byte),
        .i_prog_clear  (i_prog_clear),
        .i_step        (i_step),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc),
        .o_instr_valid (o_instr_valid),
        .o_halted      (o_halted)
    );

    initial
    begin
        i_WriteDebug = 1'b0;
        forever #2 i_WriteDebug = ~i_WriteDebug;
    end

    task automatic check_value(input string name, input logic [NBITS-1:0] expected,
                               input logic [NBITS-1:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value check failed");
        end
    endtask

    // index of the first halt word in the expected image
    function automatic int halt_index();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            if (img_word[i] == fetch_pkg::HALT_WORD)
            begin
                return i;
            end
        end
        return MEM_WORDS;
    endfunction

    // one-cycle clear pulse, the loader and the fetch stage restart
    task automatic clear_program();
        i_prog_clear = 1'b1;
        @(negedge i_WriteDebug);
        i_prog_clear = 1'b0;
        @(negedge i_WriteDebug);
    endtask

    // send the rows of one program, msb first, random gaps between bytes
    task automatic load_program(input int prog);
        int idx;
        int gap;
        idx = 0;
        for (int r = 0; r < N_ROWS; r++)
        begin
            if (row_prog[r] == prog)
            begin
                for (int b = fetch_pkg::BYTES_PER_WORD - 1; b >= 0; b--)
                begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) @(negedge i_WriteDebug);
                    i_rx_valid = 1'b1;
                    i_rx_byte  = row_word[r][8*b +: 8];
                    @(negedge i_WriteDebug);
                    i_rx_valid = 1'b0;
                end
                img_word[idx] = row_word[r];
                img_name[idx] = row_name[r];
                idx++;
            end
        end
        // write pulse, write edge, then the word is readable
        repeat (3) @(negedge i_WriteDebug);
    endtask

    // steps back to back, or with random idle cycles in between
    task automatic run_steps(input int n, input bit spaced);
        int gap;
        for (int i = 0; i < n; i++)
        begin
            gap = spaced ? $urandom_range(2, 0) : 0;
            repeat (gap) @(negedge i_WriteDebug);
            i_step = 1'b1;
            @(negedge i_WriteDebug);
            i_step = 1'b0;
        end
    endtask

    // compare collected pulses with the image up to its halt word
    task automatic check_fetch(input string phase);
        int n;
        n = halt_index();
        while (!o_halted)
        begin
            @(negedge i_WriteDebug);
        end
        check_value({phase, " valid count"}, NBITS'(n), NBITS'(got_instr.size()));
        for (int i = 0; i < n; i++)
        begin
            check_value({phase, " ", img_name[i]}, img_word[i], got_instr[i]);
            check_value({phase, " ", img_name[i], " pc"},
                        NBITS'(i * fetch_pkg::PC_STEP), got_pc[i]);
        end
        got_instr.delete();
        got_pc.delete();
    endtask

    // monitor, step sampled on the rising edge, pulse checked mid-cycle
    initial
    begin
        forever
        begin
            @(posedge i_WriteDebug);
            step_seen = i_step;
            @(negedge i_WriteDebug);
            if (o_instr_valid)
            begin
                if (!step_seen)
                begin
                    $display("Instruction valid pulse appeared without a step in the cycle before");
                    $display("Test failed");
                    $fatal(1, "unexpected valid pulse");
                end
                got_instr.push_back(o_instr);
                got_pc.push_back(o_instr_pc);
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_WriteDebug);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        void'($urandom(32'h0807_9c4c));
        i_rst_n      = 1'b0;
        i_rx_valid   = 1'b0;
        i_rx_byte    = 8'h00;
        i_prog_clear = 1'b0;
        i_step       = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            img_word[i] = '0;
            img_name[i] = "unused";
        end
        repeat (5) @(negedge i_WriteDebug);
        i_rst_n = 1'b1;
        @(negedge i_WriteDebug);
        check_value("reset valid", '0, NBITS'(o_instr_valid));
        check_value("reset halted", '0, NBITS'(o_halted));

        // first program fetched with back to back steps
        // two extra steps land on the halt cycle and after it
        load_program(1);
        run_steps(halt_index() + 3, 1'b0);
        check_fetch("back_to_back");

        // steps while halted give nothing
        run_steps(3, 1'b1);
        repeat (2) @(negedge i_WriteDebug);
        check_value("halted steps", '0, NBITS'(got_instr.size()));
        check_value("halted level", NBITS'(1), NBITS'(o_halted));

        // same program again from pc 0, randomly spaced steps
        clear_program();
        check_value("clear halted", '0, NBITS'(o_halted));
        run_steps(halt_index() + 3, 1'b1);
        check_fetch("spaced");

        // shorter reload, old words behind it remain up to the old halt word
        clear_program();
        load_program(2);
        check_value("reload halted", '0, NBITS'(o_halted));
        run_steps(halt_index() + 3, 1'b1);
        check_fetch("reload");

        // concurrent assertions in the bound checker count their failures
        if (i_dut.u_props.fail_count == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            $display("Concurrent assertions failed %0d times", i_dut.u_props.fail_count);
            $display("Test failed");
            $fatal(1, "assertion failures recorded");
        end
    end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top
#(
    parameter int NBITS     = fetch_pkg::NBITS_DEFAULT,
    parameter int MEM_WORDS = fetch_pkg::MEM_WORDS_DEFAULT
)
(
    input  logic              i_WriteDebug,
    input  logic              i_rst_n,
    input  logic              i_rx_valid,
    input  logic [7:0]        i_rx_byte,
    input  logic              i_prog_clear,
    input  logic              i_step,
    output logic [NBITS-1:0]  o_instr,
    output logic [NBITS-1:0]  o_instr_pc,
    output logic              o_instr_valid,
    output logic              o_halted
);

    // word index width shared by both memory ports
    localparam int AW = $clog2(MEM_WORDS);

    // debug write path
    logic             wr_en;
    logic [AW-1:0]    wr_addr;
    logic [NBITS-1:0] wr_data;

    // fetch read path
    logic             rd_en;
    logic [AW-1:0]    rd_addr;
    logic [NBITS-1:0] rd_data;

    // byte stream in, word writes out
    debug_loader #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) u_loader (
        .i_WriteDebug (i_WriteDebug),
        .i_rst_n      (i_rst_n),
        .i_rx_valid   (i_rx_valid),
        .i_rx_byte    (i_rx_byte),
        .i_prog_clear (i_prog_clear),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data)
    );

    instruction_memory #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) u_imem (
        .i_WriteDebug (i_WriteDebug),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_data    (wr_data),
        .i_rd_en      (rd_en),
        .i_rd_addr    (rd_addr),
        .o_rd_data    (rd_data)
    );

    // pc, step handling and halt detection
    fetch_stage #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) u_fetch (
        .i_WriteDebug  (i_WriteDebug),
        .i_rst_n       (i_rst_n),
        .i_step        (i_step),
        .i_prog_clear  (i_prog_clear),
        .i_rd_data     (rd_data),
        .o_rd_en       (rd_en),
        .o_rd_addr     (rd_addr),
        .o_instr       (o_instr),
        .o_instr_pc    (o_instr_pc),
        .o_instr_valid (o_instr_valid),
        .o_halted      (o_halted)
    );

endmodule

// ==== files.f ====
fetch_pkg.sv
debug_loader.sv
instruction_memory.sv
fetch_stage.sv
fetch_top.sv
fetch_properties.sv
fetch_tb.sv

// ==== instruction_memory.sv ====
`timescale 1ns/10ps

module instruction_memory
#(
    parameter int NBITS     = 32,
    parameter int MEM_WORDS = 64
)
(
    input  logic                          i_WriteDebug,
    input  logic                          i_wr_en,
    input  logic [$clog2(MEM_WORDS)-1:0]  i_wr_addr,
    input  logic [NBITS-1:0]              i_wr_data,
    input  logic                          i_rd_en,
    input  logic [$clog2(MEM_WORDS)-1:0]  i_rd_addr,
    output logic [NBITS-1:0]              o_rd_data
);

    // word array, one entry per instruction
    // contents survive reset and program clear, like a block ram
    logic [NBITS-1:0] mem [MEM_WORDS];

    // debug write port
    // the loader hands over one whole word per pulse
    always_ff @(posedge i_WriteDebug)
    begin
        if (i_wr_en)
        begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // registered read port, enabled by an accepted step
    // output holds its value between reads so the instruction
    // only changes when the fetch stage asks for a new one
    // a read and a write to the same word in one cycle returns the old word
    always_ff @(posedge i_WriteDebug)
    begin
        if (i_rd_en)
        begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule
